//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_abc_trace
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qx "CHECKS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/abc_insn_classify.sv
`timescale 1ns/100ps
`default_nettype none

module abc_insn_classify
    import abc_isa_pkg::*;
    import trace_pkg::*;
(
    input  insn_t  insn,
    output phase_t phase,
    output opsrc_t opsrc
);

    // Result phase from command and subcommand
    always_comb
    begin
        phase = PH_IMMEDIATE;
        case (insn.cmd)
            OP_ALU, OP_TEST:
            begin
                // Slot bit 0 selects a RAM operand
                if (insn.slot[0])
                begin
                    phase = PH_MEM_READ;
                end
            end
            OP_APB:
            begin
                if (insn.scmd == APB_WRT_ACM || insn.scmd == APB_WRTZ_ACM)
                begin
                    phase = PH_ACM_WRITE;
                end
                else if (insn.scmd == APB_READ || insn.scmd == APB_READZ)
                begin
                    phase = PH_APB_READ;
                end
            end
            OP_MISC:
            begin
                if (insn.scmd == MISC_RAMREAD || insn.scmd == MISC_POP)
                begin
                    phase = PH_MEM_READ;
                end
            end
            default:
            begin
                phase = PH_IMMEDIATE;
            end
        endcase
    end

    // Operand source
    always_comb
    begin
        if (insn.cmd[2:1] == 2'b00 && insn.slot[0])
        begin
            opsrc = SRC_RAM;
        end
        else if (phase == PH_APB_READ)
        begin
            opsrc = SRC_PRDATA;
        end
        else if (phase == PH_ACM_WRITE)
        begin
            opsrc = SRC_PWDATA;
        end
        else
        begin
            opsrc = SRC_INSN;
        end
    end

endmodule

`default_nettype wire

//--- design/abc_isa_pkg.sv
`default_nettype none

package abc_isa_pkg;

    // Datapath and field widths
    localparam int DWIDTH   = 8;
    localparam int AWIDTH   = 8;
    localparam int ICWIDTH  = 8;
    localparam int SWIDTH   = 4;
    localparam int SPWIDTH  = 8;
    localparam int CMDWIDTH = 3;

    // Command field
    localparam logic [CMDWIDTH-1:0] OP_ALU  = 3'd0;
    localparam logic [CMDWIDTH-1:0] OP_TEST = 3'd1;
    localparam logic [CMDWIDTH-1:0] OP_APB  = 3'd2;
    localparam logic [CMDWIDTH-1:0] OP_MISC = 3'd3;
    localparam logic [CMDWIDTH-1:0] OP_JUMP = 3'd4;
    localparam logic [CMDWIDTH-1:0] OP_CALL = 3'd5;
    localparam logic [CMDWIDTH-1:0] OP_RET  = 3'd6;
    localparam logic [CMDWIDTH-1:0] OP_NOP  = 3'd7;

    // Subcommands with a late result
    localparam logic [CMDWIDTH-1:0] APB_WRT_ACM  = 3'd2;
    localparam logic [CMDWIDTH-1:0] APB_WRTZ_ACM = 3'd6;
    localparam logic [CMDWIDTH-1:0] APB_READ     = 3'd3;
    localparam logic [CMDWIDTH-1:0] APB_READZ    = 3'd7;
    localparam logic [CMDWIDTH-1:0] MISC_RAMREAD = 3'd3;
    localparam logic [CMDWIDTH-1:0] MISC_POP     = 3'd5;

    // Instruction as seen on the controller ports
    typedef struct packed {
        logic [ICWIDTH-1:0]  pc;
        logic [CMDWIDTH-1:0] cmd;
        logic [CMDWIDTH-1:0] scmd;
        logic [SWIDTH-1:0]   slot;
        logic [AWIDTH-1:0]   addr;
        logic [DWIDTH-1:0]   data;
    } insn_t;

endpackage

`default_nettype wire

//--- design/abc_trace_capture.sv
`timescale 1ns/100ps
`default_nettype none

module abc_trace_capture
    import abc_isa_pkg::*;
    import trace_pkg::*;
(
    input  logic               PCLKD,
    input  logic               rst_n,
    input  logic               trace_en,
    input  insn_t              insn,
    input  phase_t             phase,
    input  opsrc_t             opsrc,
    input  logic [DWIDTH-1:0]  ram_dout,
    input  logic [DWIDTH-1:0]  prdata,
    input  logic [DWIDTH-1:0]  pwdata,
    input  logic [DWIDTH-1:0]  acc_old,
    input  logic [DWIDTH-1:0]  acc_new,
    input  logic               flag,
    input  logic [SPWIDTH-1:0] sp,
    input  logic               isr,
    input  logic               debug1,
    input  logic               debug2,
    output trace_rec_t         rec,
    output logic               rec_valid,
    output isr_evt_t           evt,
    output logic               evt_valid
);

    logic              debug1_q;
    logic              in_isr;
    logic              qualify;
    logic              isr_change;
    logic [DWIDTH-1:0] operand;
    trace_rec_t        rec_d;

    // Late phases use debug1 from the previous edge
    assign qualify = trace_en &&
                     ((phase == PH_IMMEDIATE && debug1) ||
                      ((phase == PH_MEM_READ || phase == PH_ACM_WRITE) && debug1_q) ||
                      (phase == PH_APB_READ && debug2));

    assign isr_change = (isr != in_isr);

    always_comb
    begin
        case (opsrc)
            SRC_RAM:    operand = ram_dout;
            SRC_PRDATA: operand = prdata;
            SRC_PWDATA: operand = pwdata;
            default:    operand = insn.data;
        endcase
    end

    always_comb
    begin
        rec_d.pc      = insn.pc;
        rec_d.cmd     = insn.cmd;
        rec_d.scmd    = insn.scmd;
        rec_d.slot    = insn.slot;
        rec_d.addr    = insn.addr;
        rec_d.operand = operand;
        rec_d.acc_old = acc_old;
        rec_d.acc_new = acc_new;
        rec_d.flag    = flag;
        rec_d.sp      = sp;
    end

    // Qualifier and ISR state track inputs even when tracing is off
    always_ff @(posedge PCLKD)
    begin
        if (!rst_n)
        begin
            debug1_q  <= 1'b0;
            in_isr    <= 1'b0;
            rec_valid <= 1'b0;
            evt_valid <= 1'b0;
        end
        else
        begin
            debug1_q  <= debug1;
            in_isr    <= isr;
            rec_valid <= qualify;
            evt_valid <= trace_en && isr_change;
        end
    end

    always_ff @(posedge PCLKD)
    begin
        if (qualify)
        begin
            rec <= rec_d;
        end
        if (isr_change)
        begin
            evt.enter <= isr;
            evt.sp    <= sp;
        end
    end

endmodule

`default_nettype wire

//--- design/abc_trace_top.sv
`timescale 1ns/100ps
`default_nettype none

module abc_trace_top
    import abc_isa_pkg::*;
    import trace_pkg::*;
(
    input  logic               PCLKD,
    input  logic               rst_n,
    input  logic               trace_en,
    input  insn_t              insn,
    input  logic [DWIDTH-1:0]  ram_dout,
    input  logic [DWIDTH-1:0]  prdata,
    input  logic [DWIDTH-1:0]  pwdata,
    input  logic [DWIDTH-1:0]  acc_old,
    input  logic [DWIDTH-1:0]  acc_new,
    input  logic               flag,
    input  logic [SPWIDTH-1:0] sp,
    input  logic               isr,
    input  logic               debug1,
    input  logic               debug2,
    output trace_rec_t         rec,
    output logic               rec_valid,
    output isr_evt_t           evt,
    output logic               evt_valid
);

    phase_t phase;
    opsrc_t opsrc;

    abc_insn_classify u_classify (
        .insn  (insn),
        .phase (phase),
        .opsrc (opsrc)
    );

    abc_trace_capture u_capture (
        .PCLKD     (PCLKD),
        .rst_n     (rst_n),
        .trace_en  (trace_en),
        .insn      (insn),
        .phase     (phase),
        .opsrc     (opsrc),
        .ram_dout  (ram_dout),
        .prdata    (prdata),
        .pwdata    (pwdata),
        .acc_old   (acc_old),
        .acc_new   (acc_new),
        .flag      (flag),
        .sp        (sp),
        .isr       (isr),
        .debug1    (debug1),
        .debug2    (debug2),
        .rec       (rec),
        .rec_valid (rec_valid),
        .evt       (evt),
        .evt_valid (evt_valid)
    );

endmodule

`default_nettype wire

//--- design/trace_pkg.sv
`default_nettype none

package trace_pkg;

    import abc_isa_pkg::*;

    // Cycle in which the instruction result is visible
    typedef enum logic [1:0] {
        PH_IMMEDIATE = 2'd0,
        PH_APB_READ  = 2'd1,
        PH_MEM_READ  = 2'd2,
        PH_ACM_WRITE = 2'd3
    } phase_t;

    // Bus that carries the recorded operand
    typedef enum logic [1:0] {
        SRC_INSN   = 2'd0,
        SRC_RAM    = 2'd1,
        SRC_PRDATA = 2'd2,
        SRC_PWDATA = 2'd3
    } opsrc_t;

    typedef struct packed {
        logic [ICWIDTH-1:0]  pc;
        logic [CMDWIDTH-1:0] cmd;
        logic [CMDWIDTH-1:0] scmd;
        logic [SWIDTH-1:0]   slot;
        logic [AWIDTH-1:0]   addr;
        logic [DWIDTH-1:0]   operand;
        logic [DWIDTH-1:0]   acc_old;
        logic [DWIDTH-1:0]   acc_new;
        logic                flag;
        logic [SPWIDTH-1:0]  sp;
    } trace_rec_t;

    // ISR entry when enter is set, exit otherwise
    typedef struct packed {
        logic               enter;
        logic [SPWIDTH-1:0] sp;
    } isr_evt_t;

endpackage

`default_nettype wire

//--- dv/abc_trace_assert.sv
`timescale 1ns/100ps
`default_nettype none

module abc_trace_assert
    import trace_pkg::*;
(
    input logic     PCLKD,
    input logic     rst_n,
    input logic     trace_en,
    input logic     rec_valid,
    input isr_evt_t evt,
    input logic     evt_valid
);

    logic last_enter;
    logic have_last;

    // ISR changes go unreported while tracing is off
    always_ff @(posedge PCLKD)
    begin
        if (!rst_n || !trace_en)
        begin
            have_last <= 1'b0;
        end
        else if (evt_valid)
        begin
            have_last <= 1'b1;
        end
        if (evt_valid)
        begin
            last_enter <= evt.enter;
        end
    end

    assert property (@(posedge PCLKD) !rst_n |=> !rec_valid)
        else $error("rec_valid high in the cycle after reset");

    // Consecutive events alternate while tracing stays on
    assert property (@(posedge PCLKD) disable iff (!rst_n)
        (evt_valid && have_last) |-> (evt.enter != last_enter))
        else $error("ISR event repeats the enter value of the previous event");

    assert property (@(posedge PCLKD) disable iff (!rst_n)
        rec_valid |-> $past(trace_en))
        else $error("rec_valid without trace_en at the previous edge");

endmodule

bind abc_trace_capture abc_trace_assert u_assert (
    .PCLKD     (PCLKD),
    .rst_n     (rst_n),
    .trace_en  (trace_en),
    .rec_valid (rec_valid),
    .evt       (evt),
    .evt_valid (evt_valid)
);

`default_nettype wire

//--- dv/tb_abc_trace.sv
`timescale 1ns/100ps
`default_nettype none

module tb_abc_trace
    import abc_isa_pkg::*;
    import trace_pkg::*;
();

    logic               PCLKD;
    logic               rst_n;
    logic               trace_en;
    insn_t              insn;
    logic [DWIDTH-1:0]  ram_dout, prdata, pwdata, acc_old, acc_new;
    logic [SPWIDTH-1:0] sp;
    logic               flag, isr, debug1, debug2;
    trace_rec_t         rec;
    logic               rec_valid;
    isr_evt_t           evt;
    logic               evt_valid;

    // Model state
    logic m_d1q = 1'b0;
    logic m_isr = 1'b0;
    logic en_level = 1'b1;
    int   errors = 0;
    int   n_checks = 0;
    int   n_rec = 0;
    int   n_evt = 0;
    int   err0 = 0;
    int   rec0 = 0;
    int   evt0 = 0;
    int   cnt;

    tb_clkgen u_clkgen (.PCLKD(PCLKD), .rst_n(rst_n));

    abc_trace_top UUT (
        .PCLKD     (PCLKD),
        .rst_n     (rst_n),
        .trace_en  (trace_en),
        .insn      (insn),
        .ram_dout  (ram_dout),
        .prdata    (prdata),
        .pwdata    (pwdata),
        .acc_old   (acc_old),
        .acc_new   (acc_new),
        .flag      (flag),
        .sp        (sp),
        .isr       (isr),
        .debug1    (debug1),
        .debug2    (debug2),
        .rec       (rec),
        .rec_valid (rec_valid),
        .evt       (evt),
        .evt_valid (evt_valid)
    );

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic phase_t model_phase(input insn_t i);
        phase_t ph;
        ph = PH_IMMEDIATE;
        if ((i.cmd == 3'd0 || i.cmd == 3'd1) && i.slot[0]) ph = PH_MEM_READ;
        if (i.cmd == 3'd2 && (i.scmd == 3'd2 || i.scmd == 3'd6)) ph = PH_ACM_WRITE;
        if (i.cmd == 3'd2 && (i.scmd == 3'd3 || i.scmd == 3'd7)) ph = PH_APB_READ;
        if (i.cmd == 3'd3 && (i.scmd == 3'd3 || i.scmd == 3'd5)) ph = PH_MEM_READ;
        return ph;
    endfunction

    function automatic logic [7:0] model_operand(input insn_t i, input phase_t ph);
        if (i.cmd[2:1] == 2'b00 && i.slot[0]) return ram_dout;
        if (ph == PH_APB_READ) return prdata;
        if (ph == PH_ACM_WRITE) return pwdata;
        return i.data;
    endfunction

    // Mode 1 idle, 2 immediate, 3 late phases, 4 APB reads, others fully random
    task automatic drive(input int mode);
        logic coin;
        int   pick;
        coin = 1'($urandom);
        pick = $urandom_range(0, 2);
        insn.pc = 8'($urandom);
        insn.cmd = 3'($urandom);
        insn.scmd = 3'($urandom);
        insn.slot = 4'($urandom);
        insn.addr = 8'($urandom);
        insn.data = 8'($urandom);
        ram_dout = 8'($urandom);
        prdata = 8'($urandom);
        pwdata = 8'($urandom);
        acc_old = 8'($urandom);
        acc_new = 8'($urandom);
        sp = 8'($urandom);
        flag = 1'($urandom);
        debug1 = (mode == 1) ? 1'b0 : 1'($urandom);
        debug2 = (mode == 1) ? 1'b0 : 1'($urandom);
        isr = (mode >= 5) ? 1'($urandom) : 1'b0;
        trace_en = en_level;
        if (mode == 2)
        begin
            insn.cmd = (pick == 0) ? OP_JUMP : ((pick == 1) ? OP_NOP : OP_ALU);
            insn.slot[0] = 1'b0;
        end
        else if (mode == 3)
        begin
            insn.cmd = (pick == 0) ? (coin ? OP_TEST : OP_ALU) : ((pick == 1) ? OP_MISC : OP_APB);
            insn.slot[0] = (pick == 0) ? 1'b1 : insn.slot[0];
            if (pick == 1) insn.scmd = coin ? MISC_RAMREAD : MISC_POP;
            if (pick == 2) insn.scmd = coin ? APB_WRT_ACM : APB_WRTZ_ACM;
        end
        else if (mode == 4)
        begin
            insn.cmd = OP_APB;
            insn.scmd = coin ? APB_READ : APB_READZ;
        end
    endtask

    // Predict at the edge, then drive new inputs and check at the falling edge
    task automatic step(input int mode);
        phase_t     ph;
        trace_rec_t exp_rec;
        isr_evt_t   exp_evt;
        logic       exp_rv;
        logic       exp_ev;
        @(posedge PCLKD);
        ph = model_phase(insn);
        exp_rv = trace_en && ((ph == PH_IMMEDIATE && debug1) || (ph == PH_APB_READ && debug2) ||
                              ((ph == PH_MEM_READ || ph == PH_ACM_WRITE) && m_d1q));
        exp_ev = trace_en && (isr != m_isr);
        exp_rec = {insn.pc, insn.cmd, insn.scmd, insn.slot, insn.addr,
                   model_operand(insn, ph), acc_old, acc_new, flag, sp};
        exp_evt = {isr, sp};
        m_d1q = debug1;
        m_isr = isr;
        #1;
        drive(mode);
        @(negedge PCLKD);
        check("rec_valid", 64'(rec_valid), 64'(exp_rv));
        check("evt_valid", 64'(evt_valid), 64'(exp_ev));
        if (exp_rv) check("rec", 64'(rec), 64'(exp_rec));
        if (exp_ev) check("evt", 64'(evt), 64'(exp_evt));
        if (rec_valid === 1'b1) n_rec++;
        if (evt_valid === 1'b1) n_evt++;
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: records %0d events %0d errors %0d",
                 num, name, n_rec - rec0, n_evt - evt0, errors - err0);
        err0 = errors;
        rec0 = n_rec;
        evt0 = n_evt;
    endtask

    initial
    begin
        void'($urandom(32'h0bc83894));
        drive(1);
        cnt = 0;
        while (rst_n !== 1'b1 && cnt < 20)
        begin
            @(negedge PCLKD);
            check("rec_valid", 64'(rec_valid), 64'd0);
            check("evt_valid", 64'(evt_valid), 64'd0);
            cnt++;
        end
        if (rst_n !== 1'b1)
        begin
            $display("timeout waiting for reset release");
            errors++;
        end
        step(1);
        end_test(1, "reset");
        repeat (80) step(2);
        end_test(2, "immediate");
        repeat (80) step(3);
        end_test(3, "mem read and acm write");
        repeat (80) step(4);
        end_test(4, "apb read");
        repeat (80) step(5);
        if (n_evt == evt0)
        begin
            $display("no interrupt events seen with random isr");
            errors++;
        end
        end_test(5, "interrupt");
        en_level = 1'b0;
        repeat (40) step(6);
        en_level = 1'b1;
        cnt = 0;
        rec0 = n_rec;
        while (n_rec == rec0 && cnt < 50)
        begin
            step(2);
            cnt++;
        end
        if (n_rec == rec0)
        begin
            $display("timeout waiting for a record after trace_en returned high");
            errors++;
        end
        end_test(6, "enable");
        $display("tests 6, checks %0d, errors %0d", n_checks, errors);
        if (errors == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen
(
    output logic PCLKD,
    output logic rst_n
);

    initial
    begin
        PCLKD = 1'b0;
        forever #5 PCLKD = ~PCLKD;
    end

    // Reset held over five rising edges, released just after the last
    initial
    begin
        rst_n = 1'b0;
        repeat (5) @(posedge PCLKD);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- vlog.f
design/abc_isa_pkg.sv
design/trace_pkg.sv
design/abc_insn_classify.sv
design/abc_trace_capture.sv
design/abc_trace_top.sv
dv/tb_clkgen.sv
dv/abc_trace_assert.sv
dv/tb_abc_trace.sv
